// File: Makefile
TB_TOP = tb_mcu_link

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -Wno-fatal --top-module mcu_link -f mcu_link.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TB_TOP) -f mcu_link.f
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: bench/tb_mcu_link.sv
`timescale 1ns/1ps

module tb_mcu_link;

   // One SPI frame, byte 1 sits in data[63:56]
   typedef struct packed {
      logic [7:0]  cmd;
      logic [3:0]  len;
      logic        rand_data;
      logic [63:0] data;
      logic [3:0]  exp_mapper;
      logic [3:0]  exp_size;
   } frame_t;

   logic        clk = 1'b0;
   logic        reset;
   logic        sck;
   logic        mosi;
   logic        ss_n;
   logic        miso;
   logic [3:0]  mapper;
   logic [3:0]  sram_size;

   frame_t      frame_q[$];
   logic [7:0]  ref_mem [0:(2**mem_bus_pkg::RAM_AW)-1];
   logic [23:0] ref_addr;
   logic [3:0]  ref_size;
   logic [31:0] lfsr;
   int          cycle_cnt = 0;
   int          cycle_limit = 0;

   mcu_link mcu_link_inst (
      .clk       (clk),
      .reset     (reset),
      .sck       (sck),
      .mosi      (mosi),
      .ss_n      (ss_n),
      .miso      (miso),
      .mapper    (mapper),
      .sram_size (sram_size)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("Simulation finished: FAIL");
         $fatal(1, "Timeout, no end of test after %0d clock cycles", cycle_cnt);
      end
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "Stopped at first error");
      end
   endtask

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic next_rand_byte(output logic [7:0] b);
      int i;
      b = 8'h00;
      for (i = 0; i < 8; i++) begin
         lfsr = lfsr_step(lfsr);
         b = {b[6:0], lfsr[0]};
      end
   endtask

   // Address modulo 2^w, w = min(size + base, SRAM width)
   function automatic logic [9:0] eff_addr(input logic [23:0] a, input logic [3:0] size);
      int          w;
      logic [23:0] span;
      w = int'(size) + mem_bus_pkg::SIZE_BASE;
      if (w > mem_bus_pkg::RAM_AW) begin
         w = mem_bus_pkg::RAM_AW;
      end
      span = 24'd1 << w;
      return 10'(a % span);
   endfunction

   task automatic wait_clocks(input int n);
      repeat (n) @(posedge clk);
   endtask

   // Mode 0, eight clocks per half bit, MISO taken early in the high phase
   task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
      int i;
      rx = 8'h00;
      for (i = 7; i >= 0; i--) begin
         mosi <= tx[i];
         wait_clocks(8);
         sck <= 1'b1;
         @(negedge clk);
         rx[i] = miso;
         wait_clocks(8);
         sck <= 1'b0;
      end
   endtask

   //////////////////////////////////////////////////
   // Frame table
   //////////////////////////////////////////////////

   task automatic add_frame(input logic [7:0] cmd, input int len, input logic rnd,
                            input logic [63:0] data, input logic [3:0] exp_map,
                            input logic [3:0] exp_size);
      frame_t f;
      f.cmd        = cmd;
      f.len        = 4'(len);
      f.rand_data  = rnd;
      f.data       = data;
      f.exp_mapper = exp_map;
      f.exp_size   = exp_size;
      frame_q.push_back(f);
   endtask

   task automatic add_addr_frame(input logic [23:0] addr, input logic [3:0] exp_map,
                                 input logic [3:0] exp_size);
      add_frame(8'h00, 3, 1'b0, {addr, 40'h0}, exp_map, exp_size);
   endtask

   task automatic build_table();
      add_frame(8'h33, 0, 1'b0, 64'h0, 4'h3, 4'h0);
      add_frame(8'h24, 0, 1'b0, 64'h0, 4'h3, 4'h4);
      // Incrementing write then read back
      add_addr_frame(24'h000120, 4'h3, 4'h4);
      add_frame(8'h91, 8, 1'b1, 64'h0, 4'h3, 4'h4);
      add_addr_frame(24'h000120, 4'h3, 4'h4);
      add_frame(8'h81, 8, 1'b0, 64'h0, 4'h3, 4'h4);
      // Address held
      add_addr_frame(24'h000123, 4'h3, 4'h4);
      add_frame(8'h80, 4, 1'b0, 64'h0, 4'h3, 4'h4);
      // 256 byte window
      add_frame(8'h22, 0, 1'b0, 64'h0, 4'h3, 4'h2);
      add_addr_frame(24'h000105, 4'h3, 4'h2);
      add_frame(8'h90, 1, 1'b1, 64'h0, 4'h3, 4'h2);
      add_addr_frame(24'h000005, 4'h3, 4'h2);
      add_frame(8'h80, 2, 1'b0, 64'h0, 4'h3, 4'h2);
      add_frame(8'h24, 0, 1'b0, 64'h0, 4'h3, 4'h4);
      // Low address byte rolls over
      add_addr_frame(24'h0001fc, 4'h3, 4'h4);
      add_frame(8'h91, 8, 1'b1, 64'h0, 4'h3, 4'h4);
      add_addr_frame(24'h0001fc, 4'h3, 4'h4);
      add_frame(8'h81, 8, 1'b0, 64'h0, 4'h3, 4'h4);
      add_frame(8'h3b, 0, 1'b0, 64'h0, 4'hb, 4'h4);
      // Unused opcodes aimed at bytes that are read back below
      add_addr_frame(24'h000120, 4'hb, 4'h4);
      add_frame(8'h15, 3, 1'b0, 64'h00_01_20_00_00_00_00_00, 4'hb, 4'h4);
      add_frame(8'h5a, 4, 1'b1, 64'h0, 4'hb, 4'h4);
      add_frame(8'hc3, 4, 1'b1, 64'h0, 4'hb, 4'h4);
      add_frame(8'h71, 2, 1'b1, 64'h0, 4'hb, 4'h4);
      add_addr_frame(24'h000120, 4'hb, 4'h4);
      add_frame(8'h81, 8, 1'b0, 64'h0, 4'hb, 4'h4);
      add_addr_frame(24'h0001fc, 4'hb, 4'h4);
      add_frame(8'h81, 8, 1'b0, 64'h0, 4'hb, 4'h4);
   endtask

   //////////////////////////////////////////////////
   // Frame player and reference model
   //////////////////////////////////////////////////

   task automatic run_frame(input int n, input frame_t f);
      logic [7:0] tx;
      logic [7:0] rx;
      logic [7:0] exp_rx;
      logic       is_read;
      logic       is_write;
      logic       incr;
      int         k;
      is_read  = (f.cmd[7:5] == 3'b100) && !f.cmd[4];
      is_write = (f.cmd[7:5] == 3'b100) && f.cmd[4];
      incr     = f.cmd[0];
      exp_rx   = 8'h00;
      if (f.cmd[7:4] == 4'h2) begin
         ref_size = f.cmd[3:0];
      end
      @(posedge clk);
      ss_n <= 1'b0;
      wait_clocks(8);
      shift_byte(f.cmd, rx);
      for (k = 1; k <= int'(f.len); k++) begin
         if (f.rand_data) begin
            next_rand_byte(tx);
         end else begin
            tx = f.data[8*(8-k) +: 8];
         end
         // Fetched at the command byte or after the previous byte
         if (is_read) begin
            exp_rx = ref_mem[eff_addr(ref_addr, ref_size)];
            if (incr) begin
               ref_addr = ref_addr + 24'd1;
            end
         end
         shift_byte(tx, rx);
         if (is_read) begin
            check_value($sformatf("miso frame %0d byte %0d", n, k), rx, exp_rx);
         end
         if (is_write) begin
            ref_mem[eff_addr(ref_addr, ref_size)] = tx;
            if (incr) begin
               ref_addr = ref_addr + 24'd1;
            end
         end
         if (f.cmd[7:4] == 4'h0) begin
            case (k)
               1: ref_addr = {tx, 16'h0000};
               2: ref_addr[15:8] = tx;
               3: ref_addr[7:0] = tx;
               default: begin
               end
            endcase
         end
      end
      // The fetch after the last byte still moves the address
      if (is_read && incr) begin
         ref_addr = ref_addr + 24'd1;
      end
      wait_clocks(8);
      ss_n <= 1'b1;
      wait_clocks(16);
      @(negedge clk);
      check_value($sformatf("mapper frame %0d", n), mapper, f.exp_mapper);
      check_value($sformatf("sram_size frame %0d", n), sram_size, f.exp_size);
   endtask

   initial begin
      int total_bits;
      reset    = 1'b1;
      sck      = 1'b0;
      mosi     = 1'b0;
      ss_n     = 1'b1;
      lfsr     = 32'h1700f2b5;
      ref_addr = 24'h000000;
      ref_size = 4'h0;
      build_table();
      total_bits = 0;
      foreach (frame_q[i]) begin
         total_bits += (int'(frame_q[i].len) + 1) * 8;
      end
      cycle_limit = 2 * (16 + 16 * total_bits + 48 * frame_q.size());
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_value("mapper after reset", mapper, 4'h0);
      check_value("sram_size after reset", sram_size, 4'h0);
      foreach (frame_q[i]) begin
         run_frame(i, frame_q[i]);
      end
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// File: mcu_link.f
src/mcu_link_pkg.sv
src/mem_bus_pkg.sv
src/spi_byte_rx.sv
src/mcu_cmd_decode.sv
src/mcu_addr_gen.sv
src/mcu_data_path.sv
src/mcu_mem_port.sv
src/cart_sram.sv
src/mcu_link.sv
bench/tb_mcu_link.sv

// File: src/cart_sram.sv
`timescale 1ns/1ps

module cart_sram (
   input  logic                  clk,
   input  mem_bus_pkg::mem_req_t req,
   output logic [7:0]            rdata
);

   logic [7:0]                     mem [0:(2**mem_bus_pkg::RAM_AW)-1];
   logic [mem_bus_pkg::RAM_AW-1:0] ram_addr;

   // Upper bits are already masked off by the port
   assign ram_addr = req.addr[mem_bus_pkg::RAM_AW-1:0];

   always_ff @(posedge clk) begin
      if (req.wr) begin
         mem[ram_addr] <= req.wdata;
      end
      if (req.rd) begin
         rdata <= mem[ram_addr];
      end
   end

endmodule

// File: src/mcu_addr_gen.sv
`timescale 1ns/1ps

module mcu_addr_gen (
   input  logic                               clk,
   input  logic                               reset,
   input  mcu_link_pkg::cmd_ctl_t             ctl,
   input  mem_bus_pkg::xfer_t                 xfer,
   output logic [mem_bus_pkg::ADDR_W-1:0]     addr
);

   logic addr_param;

   assign addr_param = ctl.active && ctl.param.valid &&
                       (ctl.cmd.cfg.op == mcu_link_pkg::OP_SET_ADDR);

   // Bytes 1..3 carry address bits 23:16, 15:8, 7:0
   always_ff @(posedge clk) begin
      if (reset) begin
         addr <= '0;
      end else if (addr_param) begin
         case (ctl.param.idx)
            8'd1: begin
               // High byte also clears the rest
               addr <= {ctl.param.data, 16'h0000};
            end
            8'd2: begin
               addr[15:8] <= ctl.param.data;
            end
            8'd3: begin
               addr[7:0] <= ctl.param.data;
            end
            default: begin
            end
         endcase
      end else if (xfer.go && xfer.incr) begin
         addr <= addr + 1'b1;
      end
   end

endmodule

// File: src/mcu_cmd_decode.sv
`timescale 1ns/1ps

module mcu_cmd_decode (
   input  logic                    clk,
   input  logic                    reset,
   input  mcu_link_pkg::spi_byte_t rx,
   output mcu_link_pkg::cmd_ctl_t  ctl,
   output logic [3:0]              mapper,
   output logic [3:0]              sram_size
);

   mcu_link_pkg::mcu_cmd_u in_cmd;
   logic                   cmd_byte;
   logic                   param_byte;
   logic                   frame_idle;

   assign in_cmd     = rx.data;
   assign cmd_byte   = rx.valid && (rx.idx == 8'd0);
   assign param_byte = rx.valid && (rx.idx != 8'd0) && ctl.active;

   // Byte count back at zero with no strobe means ss_n went high
   assign frame_idle = !rx.valid && (rx.idx == 8'd0);

   //////////////////////////////////////////////////
   // Command latch and parameter routing
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         ctl <= '0;
      end else begin
         ctl.frame_start <= 1'b0;
         ctl.param.valid <= 1'b0;
         if (cmd_byte) begin
            ctl.cmd         <= in_cmd;
            ctl.active      <= 1'b1;
            ctl.frame_start <= 1'b1;
         end else if (param_byte) begin
            ctl.param <= rx;
         end else if (frame_idle) begin
            ctl.active <= 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////
   // Configuration registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         mapper    <= 4'd0;
         sram_size <= 4'd0;
      end else if (cmd_byte) begin
         case (in_cmd.cfg.op)
            mcu_link_pkg::OP_SET_SIZE: begin
               sram_size <= in_cmd.cfg.value;
            end
            mcu_link_pkg::OP_SET_MAPPER: begin
               mapper <= in_cmd.cfg.value;
            end
            default: begin
            end
         endcase
      end
   end

endmodule

// File: src/mcu_data_path.sv
`timescale 1ns/1ps

module mcu_data_path (
   input  logic                   clk,
   input  logic                   reset,
   input  mcu_link_pkg::cmd_ctl_t ctl,
   input  mem_bus_pkg::mem_rsp_t  rsp,
   output logic                   rd,
   output logic                   wr,
   output logic [7:0]             wdata,
   output mem_bus_pkg::xfer_t     xfer,
   output logic [7:0]             tx_data,
   output logic                   tx_load
);

   logic mem_cmd;
   logic do_write;
   logic do_read;

   assign mem_cmd  = ctl.active && (ctl.cmd.mem.cls == mcu_link_pkg::OP_MEM_CLASS);
   assign do_write = mem_cmd && ctl.cmd.mem.write && ctl.param.valid;

   // Prefetch on the command byte and after every later byte
   assign do_read  = mem_cmd && !ctl.cmd.mem.write &&
                     (ctl.frame_start || ctl.param.valid);

   always_ff @(posedge clk) begin
      if (reset) begin
         rd      <= 1'b0;
         wr      <= 1'b0;
         xfer    <= '0;
         tx_load <= 1'b0;
      end else begin
         rd        <= do_read;
         wr        <= do_write;
         xfer.go   <= do_read || do_write;
         xfer.incr <= ctl.cmd.mem.incr;
         tx_load   <= rsp.rvalid;
      end
   end

   // Payload registers
   always_ff @(posedge clk) begin
      if (do_write) begin
         wdata <= ctl.param.data;
      end
      if (rsp.rvalid) begin
         tx_data <= rsp.rdata;
      end
   end

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
      !(rd && wr));

endmodule

// File: src/mcu_link.sv
`timescale 1ns/1ps

module mcu_link (
   input  logic       clk,
   input  logic       reset,
   input  logic       sck,
   input  logic       mosi,
   input  logic       ss_n,
   output logic       miso,
   output logic [3:0] mapper,
   output logic [3:0] sram_size
);

   mcu_link_pkg::spi_byte_t        rx;
   mcu_link_pkg::cmd_ctl_t         ctl;
   mem_bus_pkg::xfer_t             xfer;
   mem_bus_pkg::mem_req_t          req;
   mem_bus_pkg::mem_rsp_t          rsp;
   logic [mem_bus_pkg::ADDR_W-1:0] addr;
   logic                           rd;
   logic                           wr;
   logic [7:0]                     wdata;
   logic [7:0]                     tx_data;
   logic                           tx_load;
   logic [7:0]                     ram_rdata;

   //////////////////////////////////////////////////
   // SPI front end and command decode
   //////////////////////////////////////////////////

   spi_byte_rx spi_byte_rx_inst (
      .clk     (clk),
      .reset   (reset),
      .sck     (sck),
      .mosi    (mosi),
      .ss_n    (ss_n),
      .miso    (miso),
      .rx      (rx),
      .tx_data (tx_data),
      .tx_load (tx_load)
   );

   mcu_cmd_decode mcu_cmd_decode_inst (
      .clk       (clk),
      .reset     (reset),
      .rx        (rx),
      .ctl       (ctl),
      .mapper    (mapper),
      .sram_size (sram_size)
   );

   //////////////////////////////////////////////////
   // Address and data, side by side
   //////////////////////////////////////////////////

   mcu_addr_gen mcu_addr_gen_inst (
      .clk   (clk),
      .reset (reset),
      .ctl   (ctl),
      .xfer  (xfer),
      .addr  (addr)
   );

   mcu_data_path mcu_data_path_inst (
      .clk     (clk),
      .reset   (reset),
      .ctl     (ctl),
      .rsp     (rsp),
      .rd      (rd),
      .wr      (wr),
      .wdata   (wdata),
      .xfer    (xfer),
      .tx_data (tx_data),
      .tx_load (tx_load)
   );

   //////////////////////////////////////////////////
   // Save memory
   //////////////////////////////////////////////////

   mcu_mem_port mcu_mem_port_inst (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .rd        (rd),
      .wr        (wr),
      .wdata     (wdata),
      .sram_size (sram_size),
      .req       (req),
      .rsp       (rsp),
      .ram_rdata (ram_rdata)
   );

   cart_sram cart_sram_inst (
      .clk   (clk),
      .req   (req),
      .rdata (ram_rdata)
   );

endmodule

// File: src/mcu_link_pkg.sv
package mcu_link_pkg;

   //////////////////////////////////////////////////
   // Command opcodes
   //////////////////////////////////////////////////

   // Upper nibble of a configuration command
   localparam logic [3:0] OP_SET_ADDR   = 4'h0;
   localparam logic [3:0] OP_SET_SIZE   = 4'h2;
   localparam logic [3:0] OP_SET_MAPPER = 4'h3;

   // Upper three bits of a memory command (0x8x read, 0x9x write)
   localparam logic [2:0] OP_MEM_CLASS  = 3'h4;

   //////////////////////////////////////////////////
   // Command byte views
   //////////////////////////////////////////////////

   typedef struct packed {
      logic [3:0] op;
      logic [3:0] value;
   } cmd_cfg_t;

   typedef struct packed {
      logic [2:0] cls;
      logic       write;
      logic [2:0] spare;
      logic       incr;
   } cmd_mem_t;

   typedef union packed {
      cmd_cfg_t cfg;
      cmd_mem_t mem;
   } mcu_cmd_u;

   //////////////////////////////////////////////////
   // Byte stream and decoded control
   //////////////////////////////////////////////////

   // idx saturates at 255, byte 0 is the command
   typedef struct packed {
      logic [7:0] data;
      logic [7:0] idx;
      logic       valid;
   } spi_byte_t;

   typedef struct packed {
      mcu_cmd_u  cmd;
      logic      active;
      spi_byte_t param;
      logic      frame_start;
   } cmd_ctl_t;

endpackage

// File: src/mcu_mem_port.sv
`timescale 1ns/1ps

module mcu_mem_port (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [mem_bus_pkg::ADDR_W-1:0] addr,
   input  logic                           rd,
   input  logic                           wr,
   input  logic [7:0]                     wdata,
   input  logic [3:0]                     sram_size,
   output mem_bus_pkg::mem_req_t          req,
   output mem_bus_pkg::mem_rsp_t          rsp,
   input  logic [7:0]                     ram_rdata
);

   logic [4:0]                     mask_w;
   logic [mem_bus_pkg::ADDR_W-1:0] addr_mask;
   logic                           rvalid_q;

   //////////////////////////////////////////////////
   // Address masking
   //////////////////////////////////////////////////

   // Width is size + base, capped at the SRAM depth
   always_comb begin
      mask_w = {1'b0, sram_size} + 5'(mem_bus_pkg::SIZE_BASE);
      if (mask_w > 5'(mem_bus_pkg::RAM_AW)) begin
         mask_w = 5'(mem_bus_pkg::RAM_AW);
      end
      addr_mask = ~({mem_bus_pkg::ADDR_W{1'b1}} << mask_w);
   end

   always_comb begin
      req.rd    = rd;
      req.wr    = wr;
      req.addr  = addr & addr_mask;
      req.wdata = wdata;
   end

   //////////////////////////////////////////////////
   // Response timing
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd;
      end
   end

   assign rsp.rvalid = rvalid_q;
   assign rsp.rdata  = ram_rdata;

   a_addr_in_ram: assert property (@(posedge clk) disable iff (reset)
      (req.rd || req.wr) |->
         (req.addr[mem_bus_pkg::ADDR_W-1:mem_bus_pkg::RAM_AW] == '0));

endmodule

// File: src/mem_bus_pkg.sv
package mem_bus_pkg;

   // Link address, SRAM address, and base of the size mask
   localparam int ADDR_W    = 24;
   localparam int RAM_AW    = 10;
   localparam int SIZE_BASE = 6;

   typedef struct packed {
      logic              rd;
      logic              wr;
      logic [ADDR_W-1:0] addr;
      logic [7:0]        wdata;
   } mem_req_t;

   typedef struct packed {
      logic       rvalid;
      logic [7:0] rdata;
   } mem_rsp_t;

   // Transfer done, from data path to address generator
   typedef struct packed {
      logic go;
      logic incr;
   } xfer_t;

endpackage

// File: src/spi_byte_rx.sv
`timescale 1ns/1ps

module spi_byte_rx (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   sck,
   input  logic                   mosi,
   input  logic                   ss_n,
   output logic                   miso,
   output mcu_link_pkg::spi_byte_t rx,
   input  logic [7:0]             tx_data,
   input  logic                   tx_load
);

   logic [1:0] sck_sync;
   logic [1:0] mosi_sync;
   logic [1:0] ss_sync;
   logic       sck_prev;
   logic       sck_rise;
   logic       sck_fall;
   logic       ss_active;
   logic [2:0] bit_cnt;
   logic [7:0] byte_cnt;
   logic [7:0] rx_shift;
   logic       byte_done;
   logic [7:0] tx_buf;
   logic [7:0] tx_shift;
   logic [7:0] tx_next;

   //////////////////////////////////////////////////
   // Pin synchronizers and edge detect
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         sck_sync  <= 2'b00;
         mosi_sync <= 2'b00;
         ss_sync   <= 2'b11;
         sck_prev  <= 1'b0;
      end else begin
         sck_sync  <= {sck_sync[0], sck};
         mosi_sync <= {mosi_sync[0], mosi};
         ss_sync   <= {ss_sync[0], ss_n};
         sck_prev  <= sck_sync[1];
      end
   end

   assign sck_rise  = sck_sync[1] & ~sck_prev;
   assign sck_fall  = ~sck_sync[1] & sck_prev;
   assign ss_active = ~ss_sync[1];

   //////////////////////////////////////////////////
   // Receive side
   //////////////////////////////////////////////////

   // Counters only run inside a frame
   always_ff @(posedge clk) begin
      if (reset || !ss_active) begin
         bit_cnt   <= 3'd0;
         byte_cnt  <= 8'd0;
         byte_done <= 1'b0;
      end else begin
         byte_done <= sck_rise && (bit_cnt == 3'd7);
         if (sck_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
         end
         if (byte_done && byte_cnt != 8'hff) begin
            byte_cnt <= byte_cnt + 8'd1;
         end
      end
   end

   // MSB first, sampled on rising sck
   always_ff @(posedge clk) begin
      if (sck_rise) begin
         rx_shift <= {rx_shift[6:0], mosi_sync[1]};
      end
   end

   // idx holds the byte position on the strobe, live count otherwise
   always_ff @(posedge clk) begin
      if (reset) begin
         rx.valid <= 1'b0;
         rx.idx   <= 8'd0;
      end else begin
         rx.valid <= byte_done;
         rx.idx   <= byte_cnt;
      end
      if (byte_done) begin
         rx.data <= rx_shift;
      end
   end

   //////////////////////////////////////////////////
   // Transmit side
   //////////////////////////////////////////////////

   // A load in the boundary cycle goes straight out
   assign tx_next = tx_load ? tx_data : tx_buf;

   always_ff @(posedge clk) begin
      if (reset || !ss_active) begin
         miso     <= 1'b0;
         tx_buf   <= 8'h00;
         tx_shift <= 8'h00;
      end else if (sck_fall && bit_cnt == 3'd0) begin
         // Byte boundary, start the next reply
         miso     <= tx_next[7];
         tx_shift <= {tx_next[6:0], 1'b0};
         tx_buf   <= 8'h00;
      end else begin
         if (sck_fall) begin
            miso     <= tx_shift[7];
            tx_shift <= {tx_shift[6:0], 1'b0};
         end
         if (tx_load) begin
            tx_buf <= tx_data;
         end
      end
   end

   a_valid_in_frame: assert property (@(posedge clk) disable iff (reset)
      rx.valid |-> ss_active);

endmodule
